/* hdl/id_remap_pkg.sv */
package id_remap_pkg;

  // Upstream IDs are wide and sparsely used
  localparam int unsigned IN_ID_W         = 8;
  // One table entry per distinct input ID in flight, per direction
  localparam int unsigned MAX_UNIQ_IDS    = 4;
  localparam int unsigned MAX_TXNS_PER_ID = 3;
  localparam int unsigned IDX_W           = $clog2(MAX_UNIQ_IDS);
  // Downstream IDs carry the table index, zero-extended to this width
  localparam int unsigned OUT_ID_W        = 3;
  // The counter must be able to hold MAX_TXNS_PER_ID itself
  localparam int unsigned CNT_W           = $clog2(MAX_TXNS_PER_ID + 1);
  localparam int unsigned ADDR_W          = 32;
  localparam int unsigned LEN_W           = 8;
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned RESP_W          = 2;

  typedef logic [IN_ID_W-1:0]      in_id_t;
  typedef logic [OUT_ID_W-1:0]     out_id_t;
  typedef logic [IDX_W-1:0]        idx_t;
  typedef logic [CNT_W-1:0]        cnt_t;
  // One bit per table entry
  typedef logic [MAX_UNIQ_IDS-1:0] field_t;
  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [LEN_W-1:0]        len_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [RESP_W-1:0]       resp_t;

  // AR and AW share one request layout
  typedef struct packed {
    in_id_t id;
    addr_t  addr;
    len_t   len;
  } in_ax_t;

  typedef struct packed {
    out_id_t id;
    addr_t   addr;
    len_t    len;
  } out_ax_t;

  typedef struct packed {
    in_id_t id;
    data_t  data;
    resp_t  resp;
    logic   last;
  } in_r_t;

  typedef struct packed {
    out_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } out_r_t;

  typedef struct packed {
    in_id_t id;
    resp_t  resp;
  } in_b_t;

  typedef struct packed {
    out_id_t id;
    resp_t   resp;
  } out_b_t;

  // The request issuer forwards freely or holds a stalled output ID
  typedef enum logic {
    ISSUE_READY,
    ISSUE_HOLD
  } issue_state_e;

endpackage

/* hdl/id_remap_table.sv */
`timescale 1ns/1ps

module id_remap_table (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Push side driven by the request issuer
  input  logic                 push_i,
  input  id_remap_pkg::in_id_t push_in_id_i,
  input  id_remap_pkg::idx_t   push_idx_i,
  // Lookup of the incoming request ID
  input  id_remap_pkg::in_id_t lookup_id_i,
  output logic                 exists_o,
  output id_remap_pkg::idx_t   exists_idx_o,
  output logic                 exists_full_o,
  // Lowest free entry
  output id_remap_pkg::idx_t   free_idx_o,
  output logic                 full_o,
  // Pop side driven by response completion
  input  logic                 pop_i,
  input  id_remap_pkg::idx_t   pop_idx_i,
  output id_remap_pkg::in_id_t pop_in_id_o
);
  import id_remap_pkg::*;

  // Each entry is owned by one input ID while its count is nonzero
  typedef struct packed {
    in_id_t in_id;
    cnt_t   cnt;
  } entry_t;

  // Indexed by output ID
  entry_t [MAX_UNIQ_IDS-1:0] table_q;
  entry_t [MAX_UNIQ_IDS-1:0] table_d;

  field_t free_vec;
  field_t match_vec;

  // An entry with no transaction in flight is free, whatever input ID it still holds
  // Only an occupied entry can match the looked-up ID
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      free_vec[i]  = (table_q[i].cnt == '0);
      match_vec[i] = !free_vec[i] && (table_q[i].in_id == lookup_id_i);
    end
  end

  assign full_o = ~|free_vec;

  // Scan from the top so that the lowest free index wins
  always_comb begin
    free_idx_o = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_idx_o = idx_t'(i);
      end
    end
  end

  // The same scan picks the matching entry if there is one
  always_comb begin
    exists_idx_o = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        exists_idx_o = idx_t'(i);
      end
    end
  end

  assign exists_o = |match_vec;

  // Only meaningful while exists_o is high
  assign exists_full_o = (table_q[exists_idx_o].cnt == cnt_t'(MAX_TXNS_PER_ID));

  // Reverse lookup restores the upstream ID of a response
  assign pop_in_id_o = table_q[pop_idx_i].in_id;

  // Push and pop apply in sequence, so both on one entry cancel out
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[push_idx_i].in_id = push_in_id_i;
      table_d[push_idx_i].cnt   = table_d[push_idx_i].cnt + 1'b1;
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - 1'b1;
    end
  end

  // All entries start empty after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
        table_q[i].cnt <= '0;
      end
    end else begin
      table_q <= table_d;
    end
  end

  // The issuer must either claim a free entry or reuse the entry of its own ID
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (table_q[push_idx_i].cnt == '0) ||
               (table_q[push_idx_i].in_id == push_in_id_i))
    else $error("Push to an entry owned by another input ID");

  // Admission in the issuer keeps every count within the limit
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> table_q[push_idx_i].cnt < cnt_t'(MAX_TXNS_PER_ID))
    else $error("Push beyond the in-flight limit of an input ID");

  // A response must belong to a transaction that was forwarded earlier
  assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> table_q[pop_idx_i].cnt != '0)
    else $error("Pop of an entry with nothing in flight");

  // Reuse on push keeps each input ID in a single entry
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(match_vec))
    else $error("Input ID held by more than one entry");

endmodule

/* hdl/ax_issue.sv */
`timescale 1ns/1ps

module ax_issue (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Upstream request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  id_remap_pkg::in_ax_t  req_i,
  // Downstream request
  output logic                  fwd_valid_o,
  input  logic                  fwd_ready_i,
  output id_remap_pkg::out_ax_t fwd_o,
  // Table results for the current request ID
  input  logic                  exists_i,
  input  id_remap_pkg::idx_t    exists_idx_i,
  input  logic                  exists_full_i,
  input  id_remap_pkg::idx_t    free_idx_i,
  input  logic                  full_i,
  // Table push
  output logic                  push_o,
  output id_remap_pkg::idx_t    push_idx_o
);
  import id_remap_pkg::*;

  issue_state_e state_q;
  issue_state_e state_d;
  idx_t         hold_idx_q;
  idx_t         hold_idx_d;
  idx_t         fwd_idx;
  logic         admit;

  // A known ID may go while below its limit, a new ID needs a free entry
  assign admit = exists_i ? !exists_full_i : !full_i;

  always_comb begin
    state_d     = state_q;
    hold_idx_d  = hold_idx_q;
    fwd_valid_o = 1'b0;
    req_ready_o = 1'b0;
    push_o      = 1'b0;
    // Reuse keeps responses of one input ID in order downstream
    fwd_idx     = exists_i ? exists_idx_i : free_idx_i;
    unique case (state_q)
      ISSUE_READY: begin
        if (req_valid_i && admit) begin
          // The entry is claimed now, even if downstream stalls
          fwd_valid_o = 1'b1;
          push_o      = 1'b1;
          req_ready_o = fwd_ready_i;
          if (!fwd_ready_i) begin
            state_d    = ISSUE_HOLD;
            hold_idx_d = fwd_idx;
          end
        end
      end
      ISSUE_HOLD: begin
        // Table lookups may change meanwhile, so replay the stored index
        fwd_idx     = hold_idx_q;
        fwd_valid_o = 1'b1;
        req_ready_o = fwd_ready_i;
        if (fwd_ready_i) begin
          state_d = ISSUE_READY;
        end
      end
      default: begin
        state_d = ISSUE_READY;
      end
    endcase
  end

  assign push_idx_o = fwd_idx;

  // Upper ID bits are always zero
  assign fwd_o.id   = {{(OUT_ID_W - IDX_W){1'b0}}, fwd_idx};
  assign fwd_o.addr = req_i.addr;
  assign fwd_o.len  = req_i.len;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ISSUE_READY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_q <= hold_idx_d;
  end

  // A stalled request keeps its output ID until accepted
  assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_valid_o && !fwd_ready_i |=> fwd_valid_o && $stable(fwd_o.id))
    else $error("Stalled request dropped or changed its output ID");

endmodule

/* hdl/remap_direction.sv */
`timescale 1ns/1ps

module remap_direction (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Upstream request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  id_remap_pkg::in_ax_t  req_i,
  // Downstream request
  output logic                  fwd_valid_o,
  input  logic                  fwd_ready_i,
  output id_remap_pkg::out_ax_t fwd_o,
  // Response completion and ID restoration
  input  logic                  rsp_pop_i,
  input  id_remap_pkg::out_id_t rsp_out_id_i,
  output id_remap_pkg::in_id_t  rsp_in_id_o
);
  import id_remap_pkg::*;

  logic exists;
  idx_t exists_idx;
  logic exists_full;
  idx_t free_idx;
  logic full;
  logic push;
  idx_t push_idx;
  idx_t rsp_idx;

  // Only the low bits of a downstream ID index the table
  assign rsp_idx = rsp_out_id_i[IDX_W-1:0];

  ax_issue ax_issue_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req_i),
    .fwd_valid_o   (fwd_valid_o),
    .fwd_ready_i   (fwd_ready_i),
    .fwd_o         (fwd_o),
    .exists_i      (exists),
    .exists_idx_i  (exists_idx),
    .exists_full_i (exists_full),
    .free_idx_i    (free_idx),
    .full_i        (full),
    .push_o        (push),
    .push_idx_o    (push_idx)
  );

  // Lookup and push both use the ID of the request at the upstream port
  id_remap_table id_remap_table_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (push),
    .push_in_id_i  (req_i.id),
    .push_idx_i    (push_idx),
    .lookup_id_i   (req_i.id),
    .exists_o      (exists),
    .exists_idx_o  (exists_idx),
    .exists_full_o (exists_full),
    .free_idx_o    (free_idx),
    .full_o        (full),
    .pop_i         (rsp_pop_i),
    .pop_idx_i     (rsp_idx),
    .pop_in_id_o   (rsp_in_id_o)
  );

  // Completing responses carry an ID this block handed out, so its upper bits are zero
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_pop_i |-> rsp_out_id_i[OUT_ID_W-1:IDX_W] == '0)
    else $error("Response ID outside the remapped range");

endmodule

/* hdl/axi_id_remap_top.sv */
`timescale 1ns/1ps

module axi_id_remap_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Upstream port
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  id_remap_pkg::in_ax_t  ar_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  id_remap_pkg::in_ax_t  aw_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output id_remap_pkg::in_r_t   r_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output id_remap_pkg::in_b_t   b_o,
  // Downstream port
  output logic                  m_ar_valid_o,
  input  logic                  m_ar_ready_i,
  output id_remap_pkg::out_ax_t m_ar_o,
  output logic                  m_aw_valid_o,
  input  logic                  m_aw_ready_i,
  output id_remap_pkg::out_ax_t m_aw_o,
  input  logic                  m_r_valid_i,
  output logic                  m_r_ready_o,
  input  id_remap_pkg::out_r_t  m_r_i,
  input  logic                  m_b_valid_i,
  output logic                  m_b_ready_o,
  input  id_remap_pkg::out_b_t  m_b_i
);
  import id_remap_pkg::*;

  in_id_t rd_in_id;
  in_id_t wr_in_id;
  logic   rd_pop;
  logic   wr_pop;

  // A read completes on its last beat, a write on its B handshake
  assign rd_pop = m_r_valid_i && r_ready_i && m_r_i.last;
  assign wr_pop = m_b_valid_i && b_ready_i;

  remap_direction rd_dir (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (ar_valid_i),
    .req_ready_o  (ar_ready_o),
    .req_i        (ar_i),
    .fwd_valid_o  (m_ar_valid_o),
    .fwd_ready_i  (m_ar_ready_i),
    .fwd_o        (m_ar_o),
    .rsp_pop_i    (rd_pop),
    .rsp_out_id_i (m_r_i.id),
    .rsp_in_id_o  (rd_in_id)
  );

  remap_direction wr_dir (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (aw_valid_i),
    .req_ready_o  (aw_ready_o),
    .req_i        (aw_i),
    .fwd_valid_o  (m_aw_valid_o),
    .fwd_ready_i  (m_aw_ready_i),
    .fwd_o        (m_aw_o),
    .rsp_pop_i    (wr_pop),
    .rsp_out_id_i (m_b_i.id),
    .rsp_in_id_o  (wr_in_id)
  );

  // Responses pass straight through with the original ID put back
  assign r_valid_o   = m_r_valid_i;
  assign m_r_ready_o = r_ready_i;
  assign r_o.id      = rd_in_id;
  assign r_o.data    = m_r_i.data;
  assign r_o.resp    = m_r_i.resp;
  assign r_o.last    = m_r_i.last;

  assign b_valid_o   = m_b_valid_i;
  assign m_b_ready_o = b_ready_i;
  assign b_o.id      = wr_in_id;
  assign b_o.resp    = m_b_i.resp;

endmodule

/* sim/tb_axi_id_remap.sv */
`timescale 1ns/1ps

module tb_axi_id_remap;
  import id_remap_pkg::*;

  // Requests generated per direction
  localparam int NUM_TXNS = 40;
  // Forty cycles per transaction in both directions, plus reset and drain margin
  localparam int TIMEOUT_CYCLES = 40 * 2 * NUM_TXNS + 200;

  // An accepted request and the input ID it came in with
  typedef struct packed {
    in_id_t  in_id;
    out_ax_t req;
  } pend_t;

  logic    clk_i = 1'b0;
  logic    reset_i;
  logic    ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  in_ax_t  ar_i, aw_i;
  logic    r_valid_o, r_ready_i, b_valid_o, b_ready_i;
  in_r_t   r_o;
  in_b_t   b_o;
  logic    m_ar_valid_o, m_ar_ready_i, m_aw_valid_o, m_aw_ready_i;
  out_ax_t m_ar_o, m_aw_o;
  logic    m_r_valid_i, m_r_ready_o, m_b_valid_i, m_b_ready_o;
  out_r_t  m_r_i;
  out_b_t  m_b_i;

  int      seed = 32'h2fb2_3855;
  in_id_t  id_pool [6] = '{8'h03, 8'h5a, 8'h81, 8'hc4, 8'h27, 8'hfe};
  // Shadow remap tables with index 0 for reads and 1 for writes
  int      sh_cnt [2][MAX_UNIQ_IDS];
  in_id_t  sh_owner [2][MAX_UNIQ_IDS];
  logic    held [2] = '{1'b0, 1'b0};
  out_ax_t held_req [2];
  pend_t   rd_q[$];
  pend_t   wr_q[$];
  len_t    rd_beat = '0;
  logic    ar_fire = 1'b0, aw_fire = 1'b0, r_fire = 1'b0, b_fire = 1'b0;
  int      rd_sent, wr_sent, stall_cycles, hold_cycles, cycle_cnt;

  axi_id_remap_top axi_id_remap_top_i (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at the first mismatch");
    end
  endtask

  // Reuse the entry of an in-flight ID below its limit, otherwise take the lowest free entry
  // A result of -1 means the request must wait
  function automatic int predict_idx(input int dir, input in_id_t id);
    int free_idx;
    free_idx = -1;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (sh_cnt[dir][i] == 0) free_idx = i;
    end
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      if (sh_cnt[dir][i] != 0 && sh_owner[dir][i] == id) begin
        return (sh_cnt[dir][i] < MAX_TXNS_PER_ID) ? i : -1;
      end
    end
    return free_idx;
  endfunction

  // Responder data is a function of address and beat number
  function automatic data_t beat_data(input addr_t addr, input len_t beat);
    return ~addr + data_t'(beat);
  endfunction

  task automatic make_request(output in_ax_t req);
    int pick;
    pick     = $unsigned($random(seed)) % 6;
    req.id   = id_pool[pick];
    req.addr = $random(seed);
    req.len  = len_t'($random(seed) & 3);
  endtask

  task automatic check_request(input int dir, input logic up_valid, input logic up_ready,
                               input in_ax_t up_req, input logic dn_valid,
                               input logic dn_ready, input out_ax_t dn_req,
                               output logic accepted, output pend_t item);
    int      idx;
    out_ax_t exp;
    accepted = 1'b0;
    item     = '0;
    if (held[dir]) begin
      // A stalled request stays put until the downstream takes it
      hold_cycles++;
      check_eq(64'(dn_valid), 64'(1'b1), "held request dropped its valid");
      check_eq(64'(dn_req), 64'(held_req[dir]), "held request changed its ID or payload");
    end else if (up_valid) begin
      idx = predict_idx(dir, up_req.id);
      if (idx < 0) begin
        stall_cycles++;
        check_eq(64'(dn_valid), 64'(1'b0), "request forwarded beyond the in-flight limits");
      end else begin
        exp.id   = out_id_t'(idx);
        exp.addr = up_req.addr;
        exp.len  = up_req.len;
        check_eq(64'(dn_valid), 64'(1'b1), "admissible request not forwarded");
        check_eq(64'(dn_req), 64'(exp), "forwarded request with wrong output ID or payload");
        // The entry is claimed in the admitting cycle, even under a stall
        sh_owner[dir][idx] = up_req.id;
        sh_cnt[dir][idx]++;
      end
    end else begin
      check_eq(64'(dn_valid), 64'(1'b0), "downstream request without an upstream one");
    end
    if (dn_valid) begin
      check_eq(64'(up_ready), 64'(dn_ready), "upstream ready differs from downstream ready");
      held[dir]     = !dn_ready;
      held_req[dir] = dn_req;
      accepted      = dn_ready;
      item.in_id    = up_req.id;
      item.req      = dn_req;
    end else begin
      check_eq(64'(up_ready), 64'(1'b0), "upstream ready without a forwarded request");
    end
  endtask

  // Everything has settled for the next rising edge at the falling edge
  // Requests are checked before completions so that both see the pre-edge table
  always @(negedge clk_i) begin
    pend_t item;
    logic  acc;
    in_r_t exp_r;
    in_b_t exp_b;
    if (!reset_i) begin
      check_request(0, ar_valid_i, ar_ready_o, ar_i, m_ar_valid_o, m_ar_ready_i, m_ar_o,
                    acc, item);
      if (acc) rd_q.push_back(item);
      ar_fire = acc;
      check_request(1, aw_valid_i, aw_ready_o, aw_i, m_aw_valid_o, m_aw_ready_i, m_aw_o,
                    acc, item);
      if (acc) wr_q.push_back(item);
      aw_fire = acc;
      check_eq(64'(r_valid_o), 64'(m_r_valid_i), "upstream R valid differs from downstream");
      check_eq(64'(m_r_ready_o), 64'(r_ready_i), "downstream R ready differs from upstream");
      check_eq(64'(b_valid_o), 64'(m_b_valid_i), "upstream B valid differs from downstream");
      check_eq(64'(m_b_ready_o), 64'(b_ready_i), "downstream B ready differs from upstream");
      r_fire = m_r_valid_i && r_ready_i;
      if (r_fire) begin
        exp_r.id   = rd_q[0].in_id;
        exp_r.data = beat_data(rd_q[0].req.addr, rd_beat);
        exp_r.resp = rd_q[0].req.addr[1:0];
        exp_r.last = (rd_beat == rd_q[0].req.len);
        check_eq(64'(r_o), 64'(exp_r), "R beat with wrong ID or payload");
        // Only the last beat frees the read's entry
        if (exp_r.last) begin
          sh_cnt[0][rd_q[0].req.id[IDX_W-1:0]]--;
          void'(rd_q.pop_front());
          rd_beat = '0;
        end else begin
          rd_beat = rd_beat + 1'b1;
        end
      end
      b_fire = m_b_valid_i && b_ready_i;
      if (b_fire) begin
        exp_b.id   = wr_q[0].in_id;
        exp_b.resp = wr_q[0].req.addr[3:2];
        check_eq(64'(b_o), 64'(exp_b), "B response with wrong ID or resp");
        sh_cnt[1][wr_q[0].req.id[IDX_W-1:0]]--;
        void'(wr_q.pop_front());
      end
    end
  end

  task automatic drive_cycle();
    logic rsp_open;
    // Responses pause for part of every 64 cycles so that the tables fill up
    rsp_open = (cycle_cnt % 64) >= 24;
    if (!ar_valid_i || ar_fire) begin
      ar_valid_i = 1'b0;
      if (rd_sent < NUM_TXNS && ($random(seed) & 3) != 0) begin
        make_request(ar_i);
        ar_valid_i = 1'b1;
        rd_sent++;
      end
    end
    if (!aw_valid_i || aw_fire) begin
      aw_valid_i = 1'b0;
      if (wr_sent < NUM_TXNS && ($random(seed) & 3) != 0) begin
        make_request(aw_i);
        aw_valid_i = 1'b1;
        wr_sent++;
      end
    end
    // Downstream responder answers in order per direction
    if (!m_r_valid_i || r_fire) begin
      m_r_valid_i = 1'b0;
      if (rd_q.size() > 0 && rsp_open && ($random(seed) & 3) != 0) begin
        m_r_valid_i = 1'b1;
        m_r_i.id    = rd_q[0].req.id;
        m_r_i.data  = beat_data(rd_q[0].req.addr, rd_beat);
        m_r_i.resp  = rd_q[0].req.addr[1:0];
        m_r_i.last  = (rd_beat == rd_q[0].req.len);
      end
    end
    if (!m_b_valid_i || b_fire) begin
      m_b_valid_i = 1'b0;
      if (wr_q.size() > 0 && rsp_open && ($random(seed) & 3) != 0) begin
        m_b_valid_i = 1'b1;
        m_b_i.id    = wr_q[0].req.id;
        m_b_i.resp  = wr_q[0].req.addr[3:2];
      end
    end
    m_ar_ready_i = ($random(seed) & 1) != 0;
    m_aw_ready_i = ($random(seed) & 1) != 0;
    r_ready_i    = ($random(seed) & 3) != 0;
    b_ready_i    = ($random(seed) & 3) != 0;
  endtask

  function automatic logic all_done();
    return rd_sent == NUM_TXNS && wr_sent == NUM_TXNS && !ar_valid_i && !aw_valid_i &&
           rd_q.size() == 0 && wr_q.size() == 0 && !m_r_valid_i && !m_b_valid_i;
  endfunction

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with transactions still outstanding", cycle_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation did not finish in time");
    end
  end

  initial begin
    reset_i      = 1'b1;
    ar_valid_i   = 1'b0;
    aw_valid_i   = 1'b0;
    ar_i         = '0;
    aw_i         = '0;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    m_ar_ready_i = 1'b0;
    m_aw_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_b_valid_i  = 1'b0;
    m_r_i        = '0;
    m_b_i        = '0;
    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;
    while (!all_done()) begin
      @(posedge clk_i);
      #1;
      drive_cycle();
    end
    if (stall_cycles == 0 || hold_cycles == 0) begin
      $display("Traffic never filled a table or never stalled the downstream");
      $display("CHECKS FAILED");
      $fatal(1, "Back-pressure was not exercised");
    end else begin
      $display("Admission stalls: %0d cycles, held requests: %0d cycles",
               stall_cycles, hold_cycles);
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* project.f */
hdl/id_remap_pkg.sv
hdl/id_remap_table.sv
hdl/ax_issue.sv
hdl/remap_direction.sv
hdl/axi_id_remap_top.sv
sim/tb_axi_id_remap.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_axi_id_remap -f project.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_axi_id_remap > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation ended without a pass report"; exit 1; }
